// File: verilog/n64advPkg.sv
// N64 video datapath definitions

package n64advPkg;

  ////////////////////////////////////////
  // Bus widths

  // Color sample on the console bus
  localparam int colorWidthI = 7;
  // Output channel towards the ADV712x
  localparam int colorWidthO = 8;

  // Output mode codes
  localparam logic [1:0] modeRgb   = 2'd0;
  localparam logic [1:0] modeRgsb  = 2'd1;
  localparam logic [1:0] modeYpbpr = 2'd2;

  // Demux phase after the sync nibble
  localparam logic [1:0] phaseIdle  = 2'd0;
  localparam logic [1:0] phaseRed   = 2'd1;
  localparam logic [1:0] phaseGreen = 2'd2;
  localparam logic [1:0] phaseBlue  = 2'd3;

  // Bit positions in the sync nibble, all active low
  localparam int vsIdx    = 3;
  localparam int clampIdx = 2;
  localparam int hsIdx    = 1;
  localparam int csIdx    = 0;

  ////////////////////////////////////////
  // Color space conversion

  localparam int coefWidth = 9;
  localparam int prodWidth = 2 * coefWidth;
  // Three products plus growth
  localparam int sumWidth  = prodWidth + 2;
  localparam int fracBits  = 8;

  // Y row
  localparam logic signed [coefWidth-1:0] cYr  =  9'sd77;
  localparam logic signed [coefWidth-1:0] cYg  =  9'sd150;
  localparam logic signed [coefWidth-1:0] cYb  =  9'sd29;
  // Pb row
  localparam logic signed [coefWidth-1:0] cPbr = -9'sd43;
  localparam logic signed [coefWidth-1:0] cPbg = -9'sd85;
  localparam logic signed [coefWidth-1:0] cPbb =  9'sd128;
  // Pr row
  localparam logic signed [coefWidth-1:0] cPrr =  9'sd128;
  localparam logic signed [coefWidth-1:0] cPrg = -9'sd107;
  localparam logic signed [coefWidth-1:0] cPrb = -9'sd21;

  // Mid-scale for the chroma channels
  localparam logic signed [sumWidth-1:0] chromaOffset = 128;

endpackage

// File: verilog/pixelIf.sv
// Pixel link between stages

interface pixelIf;
  import n64advPkg::*;

  // One cycle per pixel, no back-pressure
  logic valid;
  // R, G, B or Y, Pb, Pr
  logic [colorWidthO-1:0] ch0;
  logic [colorWidthO-1:0] ch1;
  logic [colorWidthO-1:0] ch2;
  // Sync bits as they came from the console, active low
  logic nVSync;
  logic nHSync;
  logic nCSync;
  logic nClamp;

  // Producing stage
  modport src (output valid, ch0, ch1, ch2, nVSync, nHSync, nCSync, nClamp);
  // Consuming stage
  modport snk (input valid, ch0, ch1, ch2, nVSync, nHSync, nCSync, nClamp);

endinterface

// File: verilog/n64VideoDemux.sv
// Console video bus demultiplexer

module n64VideoDemux (
  input  logic                              VCLK,
  input  logic                              reset_i,
  input  logic                              nVDSYNC_i,
  input  logic [n64advPkg::colorWidthI-1:0] vd_i,
  pixelIf.src                               pixOut
);
  import n64advPkg::*;

  // Registered console bus
  logic                   nVDSyncQ;
  logic [colorWidthI-1:0] vdQ;

  // Color phase and partial pixel
  logic [1:0]             phase;
  logic [3:0]             syncNibble;
  logic [colorWidthO-1:0] redQ;
  logic [colorWidthO-1:0] greenQ;
  logic                   blueNow;

  // 7 to 8 bit by repeating the top bit
  function automatic logic [colorWidthO-1:0] widen(input logic [colorWidthI-1:0] sample);
    return {sample, sample[colorWidthI-1]};
  endfunction

  ////////////////////////////////////////
  // Input register

  always_ff @(posedge VCLK) begin
    vdQ <= vd_i;
  end

  // Marker idles high
  always_ff @(posedge VCLK) begin
    if (reset_i) begin
      nVDSyncQ <= 1'b1;
    end else begin
      nVDSyncQ <= nVDSYNC_i;
    end
  end

  ////////////////////////////////////////
  // Phase tracking

  // Sync marker restarts at red; blue wraps back to idle
  always_ff @(posedge VCLK) begin
    if (reset_i) begin
      phase <= phaseIdle;
    end else if (!nVDSyncQ) begin
      phase <= phaseRed;
    end else if (phase != phaseIdle) begin
      phase <= phase + 2'd1;
    end
  end

  // Hold sync nibble and first two colors
  always_ff @(posedge VCLK) begin
    if (!nVDSyncQ) begin
      syncNibble <= vdQ[3:0];
    end
    if (nVDSyncQ && (phase == phaseRed)) begin
      redQ <= widen(vdQ);
    end
    if (nVDSyncQ && (phase == phaseGreen)) begin
      greenQ <= widen(vdQ);
    end
  end

  // Blue on the bus completes the pixel
  // A marker before this point has already sent phase back to red
  assign blueNow = nVDSyncQ && (phase == phaseBlue);

  ////////////////////////////////////////
  // Pixel output

  always_ff @(posedge VCLK) begin
    if (reset_i) begin
      pixOut.valid <= 1'b0;
    end else begin
      pixOut.valid <= blueNow;
    end
  end

  always_ff @(posedge VCLK) begin
    if (blueNow) begin
      pixOut.ch0    <= redQ;
      pixOut.ch1    <= greenQ;
      pixOut.ch2    <= widen(vdQ);
      pixOut.nVSync <= syncNibble[vsIdx];
      pixOut.nHSync <= syncNibble[hsIdx];
      pixOut.nCSync <= syncNibble[csIdx];
      pixOut.nClamp <= syncNibble[clampIdx];
    end
  end

endmodule

// File: verilog/colorSpaceConv.sv
// RGB to YPbPr conversion

module colorSpaceConv (
  input  logic VCLK,
  input  logic reset_i,
  input  logic convEn_i,
  pixelIf.snk  pixIn,
  pixelIf.src  pixOut
);
  import n64advPkg::*;

  // Stage 1: products, indexed [output][input]
  logic signed [prodWidth-1:0] prodQ [3][3];
  // Stage 1: bypass channels and side info
  logic [colorWidthO-1:0]      rawQ  [3];
  logic                        convQ;
  logic                        validQ;
  logic [3:0]                  syncQ;

  // Stage 2: sums and scaled results
  logic signed [sumWidth-1:0]  sum    [3];
  logic signed [sumWidth-1:0]  scaled [3];

  // Channel as positive signed operand
  function automatic logic signed [prodWidth-1:0] mul(
    input logic signed [coefWidth-1:0] coef,
    input logic        [colorWidthO-1:0] chan
  );
    return coef * $signed({1'b0, chan});
  endfunction

  // Clip into the output range
  function automatic logic [colorWidthO-1:0] saturate(input logic signed [sumWidth-1:0] v);
    logic [colorWidthO-1:0] res;
    if (v < 0) begin
      res = '0;
    end else if (v > 255) begin
      res = '1;
    end else begin
      res = v[colorWidthO-1:0];
    end
    return res;
  endfunction

  ////////////////////////////////////////
  // Stage 1

  always_ff @(posedge VCLK) begin
    // Y row
    prodQ[0][0] <= mul(cYr,  pixIn.ch0);
    prodQ[0][1] <= mul(cYg,  pixIn.ch1);
    prodQ[0][2] <= mul(cYb,  pixIn.ch2);
    // Pb row
    prodQ[1][0] <= mul(cPbr, pixIn.ch0);
    prodQ[1][1] <= mul(cPbg, pixIn.ch1);
    prodQ[1][2] <= mul(cPbb, pixIn.ch2);
    // Pr row
    prodQ[2][0] <= mul(cPrr, pixIn.ch0);
    prodQ[2][1] <= mul(cPrg, pixIn.ch1);
    prodQ[2][2] <= mul(cPrb, pixIn.ch2);
    rawQ[0]     <= pixIn.ch0;
    rawQ[1]     <= pixIn.ch1;
    rawQ[2]     <= pixIn.ch2;
    // Mode select rides along with its pixel
    convQ       <= convEn_i;
    syncQ       <= {pixIn.nVSync, pixIn.nHSync, pixIn.nCSync, pixIn.nClamp};
  end

  always_ff @(posedge VCLK) begin
    if (reset_i) begin
      validQ <= 1'b0;
    end else begin
      validQ <= pixIn.valid;
    end
  end

  ////////////////////////////////////////
  // Stage 2

  always_comb begin
    for (int row = 0; row < 3; row++) begin
      sum[row]    = prodQ[row][0] + prodQ[row][1] + prodQ[row][2];
      scaled[row] = sum[row] >>> fracBits;
    end
    // Chroma centered at mid-scale
    scaled[1] = scaled[1] + chromaOffset;
    scaled[2] = scaled[2] + chromaOffset;
  end

  always_ff @(posedge VCLK) begin
    if (convQ) begin
      pixOut.ch0 <= saturate(scaled[0]);
      pixOut.ch1 <= saturate(scaled[1]);
      pixOut.ch2 <= saturate(scaled[2]);
    end else begin
      pixOut.ch0 <= rawQ[0];
      pixOut.ch1 <= rawQ[1];
      pixOut.ch2 <= rawQ[2];
    end
    pixOut.nVSync <= syncQ[3];
    pixOut.nHSync <= syncQ[2];
    pixOut.nCSync <= syncQ[1];
    pixOut.nClamp <= syncQ[0];
  end

  always_ff @(posedge VCLK) begin
    if (reset_i) begin
      pixOut.valid <= 1'b0;
    end else begin
      pixOut.valid <= validQ;
    end
  end

endmodule

// File: verilog/outputFormatter.sv
// Mode select and DAC output stage

module outputFormatter (
  input  logic                                VCLK,
  input  logic                                reset_i,
  input  logic                                nEnRgsb_i,
  input  logic                                nEnYpbpr_i,
  pixelIf.snk                                 pixIn,
  output logic                                convEn_o,
  output logic [3*n64advPkg::colorWidthO-1:0] vd_o,
  output logic                                vdValid_o,
  output logic                                nCSync_o,
  output logic                                nVSync_o,
  output logic                                nHSync_o
);
  import n64advPkg::*;

  // Jumpers as {nEnYpbpr, nEnRgsb}
  logic [1:0]             jumperMeta;
  logic [1:0]             jumperSync;
  logic [1:0]             jumperMode;
  // Mode in force for the current frame
  logic [1:0]             mode;
  logic                   prevVSync;
  logic [colorWidthO-1:0] ch1Out;

  ////////////////////////////////////////
  // Jumper synchronizer and decode

  // Open jumpers read high
  always_ff @(posedge VCLK) begin
    if (reset_i) begin
      jumperMeta <= 2'b11;
      jumperSync <= 2'b11;
    end else begin
      jumperMeta <= {nEnYpbpr_i, nEnRgsb_i};
      jumperSync <= jumperMeta;
    end
  end

  // YPbPr jumper wins over RGsB
  always_comb begin
    if (!jumperSync[1]) begin
      jumperMode = modeYpbpr;
    end else if (!jumperSync[0]) begin
      jumperMode = modeRgsb;
    end else begin
      jumperMode = modeRgb;
    end
  end

  ////////////////////////////////////////
  // Per-frame mode latch

  // Falling vsync across two valid pixels
  always_ff @(posedge VCLK) begin
    if (reset_i) begin
      mode      <= modeRgb;
      prevVSync <= 1'b1;
    end else if (pixIn.valid) begin
      prevVSync <= pixIn.nVSync;
      if (prevVSync && !pixIn.nVSync) begin
        mode <= jumperMode;
      end
    end
  end

  assign convEn_o = (mode == modeYpbpr);

  // Sync on green or Y outside plain RGB
  assign ch1Out = ((mode != modeRgb) && !pixIn.nCSync) ? '0 : pixIn.ch1;

  ////////////////////////////////////////
  // Output registers

  always_ff @(posedge VCLK) begin
    if (pixIn.valid) begin
      vd_o <= {pixIn.ch0, ch1Out, pixIn.ch2};
    end
  end

  // Syncs idle high until the first pixel
  always_ff @(posedge VCLK) begin
    if (reset_i) begin
      vdValid_o <= 1'b0;
      nCSync_o  <= 1'b1;
      nVSync_o  <= 1'b1;
      nHSync_o  <= 1'b1;
    end else begin
      vdValid_o <= pixIn.valid;
      if (pixIn.valid) begin
        nCSync_o <= pixIn.nCSync;
        nVSync_o <= pixIn.nVSync;
        nHSync_o <= pixIn.nHSync;
      end
    end
  end

endmodule

// File: verilog/n64advCore.sv
// N64 video datapath top

module n64advCore (
  // Console video bus
  input  logic                                VCLK,
  input  logic                                reset_i,
  input  logic                                nVDSYNC_i,
  input  logic [n64advPkg::colorWidthI-1:0]   vd_i,
  // Output mode jumpers, active low
  input  logic                                nEnRgsb_i,
  input  logic                                nEnYpbpr_i,
  // Towards the ADV712x
  output logic [3*n64advPkg::colorWidthO-1:0] vd_o,
  output logic                                vdValid_o,
  output logic                                nCSync_o,
  output logic                                nVSync_o,
  output logic                                nHSync_o
);

  // Pixel links
  pixelIf demuxPix ();
  pixelIf cscPix ();

  // Latched mode back to the converter
  logic convEn;

  // Rebuild RGB pixels from the nibble bus
  n64VideoDemux demux_u (
    .VCLK      (VCLK),
    .reset_i   (reset_i),
    .nVDSYNC_i (nVDSYNC_i),
    .vd_i      (vd_i),
    .pixOut    (demuxPix.src)
  );

  // Optional YPbPr matrix, two cycles either way
  colorSpaceConv csc_u (
    .VCLK     (VCLK),
    .reset_i  (reset_i),
    .convEn_i (convEn),
    .pixIn    (demuxPix.snk),
    .pixOut   (cscPix.src)
  );

  // Mode, sync insertion and output registers
  outputFormatter fmt_u (
    .VCLK       (VCLK),
    .reset_i    (reset_i),
    .nEnRgsb_i  (nEnRgsb_i),
    .nEnYpbpr_i (nEnYpbpr_i),
    .pixIn      (cscPix.snk),
    .convEn_o   (convEn),
    .vd_o       (vd_o),
    .vdValid_o  (vdValid_o),
    .nCSync_o   (nCSync_o),
    .nVSync_o   (nVSync_o),
    .nHSync_o   (nHSync_o)
  );

endmodule

// File: tb/n64advTbTests.svh
// Directed video datapath tests
`ifndef N64ADV_TB_TESTS_SVH
`define N64ADV_TB_TESTS_SVH

  // Sync pixel, vsync pixel, spacer
  task automatic enterMode();
    sendPixel(4'hF, randColor(), randColor(), randColor());
    sendPixel(4'h7, randColor(), randColor(), randColor());
    sendPixel(4'hF, randColor(), randColor(), randColor());
  endtask

  ////////////////////////////////////////
  // Tests

  task automatic testReset();
    int cycles;
    @(negedge vclk);
    if (vdValid !== 1'b0) begin
      $display("** Error: vdValid_o got 0x%h, expected 0x0 at %0t ns", vdValid, $time);
      errorCount++;
    end
    checkSync({nCSync, nVSync, nHSync}, 3'b111);
    sendPixel(4'hF, 7'h41, 7'h2a, 7'h7f);
    // Blue sampled here
    @(posedge vclk);
    cycles = 0;
    do begin
      @(posedge vclk);
      cycles++;
      #1;
    end while (!vdValid && (cycles < 16));
    if (cycles != 4) begin
      $display("First pixel appeared %0d cycles after its blue sample instead of 4", cycles);
      errorCount++;
    end
    waitDrain();
  endtask

  // Green kept even with csync low
  task automatic testRgbStream();
    sendPixel(4'hE, randColor(), randColor(), randColor());
    sendRandom(63, 4'hF, 1'b1);
    waitDrain();
  endtask

  task automatic testYpbpr();
    nEnYpbpr = 1'b0;
    nEnRgsb  = 1'b1;
    enterMode();
    sendRandom(16, 4'hF, 1'b0);
    // White, black, red, blue, yellow
    sendPixel(4'hF, 7'h7f, 7'h7f, 7'h7f);
    sendPixel(4'hF, 7'h00, 7'h00, 7'h00);
    sendPixel(4'hF, 7'h7f, 7'h00, 7'h00);
    sendPixel(4'hF, 7'h00, 7'h00, 7'h7f);
    sendPixel(4'hF, 7'h7f, 7'h7f, 7'h00);
    waitDrain();
  endtask

  task automatic testSyncOnGreen();
    nEnYpbpr = 1'b1;
    nEnRgsb  = 1'b0;
    enterMode();
    sendRandom(16, 4'hF, 1'b1);
    waitDrain();
    // Both set, YPbPr wins
    nEnYpbpr = 1'b0;
    enterMode();
    sendRandom(16, 4'hF, 1'b1);
    waitDrain();
  endtask

  task automatic testModeAtVsync();
    sendRandom(4, 4'hF, 1'b0);
    // Mid-frame switch to RGB
    nEnYpbpr = 1'b1;
    nEnRgsb  = 1'b1;
    sendRandom(6, 4'hF, 1'b0);
    sendPixel(4'h7, randColor(), randColor(), randColor());
    sendRandom(7, 4'hF, 1'b0);
    // Csync held low so the RGsB switch shows on green
    nEnRgsb = 1'b0;
    sendRandom(4, 4'hE, 1'b0);
    sendPixel(4'h6, randColor(), randColor(), randColor());
    sendRandom(7, 4'hE, 1'b0);
    waitDrain();
  endtask

  // Second marker lands where blue belongs
  task automatic testTruncated();
    sendPixel(4'hF, randColor(), randColor(), randColor());
    sendPartial(4'hF, randColor(), randColor());
    sendPixel(4'hF, randColor(), randColor(), randColor());
    sendPartial(4'hE, randColor(), randColor());
    sendPixel(4'hE, randColor(), randColor(), randColor());
    waitDrain();
  endtask

`endif

// File: tb/n64advTb.sv
// N64 video datapath testbench

module n64advTb;
  timeunit 1ns;
  timeprecision 100ps;
  import n64advPkg::*;

  // Full pixels sent over all tests
  localparam int totalPixels = 160;
  localparam int watchdogNs  = 2 * (totalPixels * 4 + 200) * 8;

  ////////////////////////////////////////
  // DUT signals

  logic                     vclk;
  logic                     reset;
  logic                     nVDSync;
  logic [colorWidthI-1:0]   vd;
  logic                     nEnRgsb;
  logic                     nEnYpbpr;
  logic [3*colorWidthO-1:0] vdOut;
  logic                     vdValid;
  logic                     nCSync;
  logic                     nVSync;
  logic                     nHSync;

  integer seed = 32'h752c;
  int     errorCount = 0;
  int     pixelsChecked = 0;

  // Expected pixels in output order
  logic [3*colorWidthO-1:0] expVd    [$];
  logic [2:0]               expSync  [$];
  bit                       expCheck [$];
  logic [3*colorWidthO-1:0] monVd;
  logic [2:0]               monSync;
  bit                       monCheck;

  // Mode model, updated as pixels are sent
  logic [1:0] curMode;
  bit         prevVs;
  bit         skipNext;

  n64advCore dut_i (
    .VCLK       (vclk),
    .reset_i    (reset),
    .nVDSYNC_i  (nVDSync),
    .vd_i       (vd),
    .nEnRgsb_i  (nEnRgsb),
    .nEnYpbpr_i (nEnYpbpr),
    .vd_o       (vdOut),
    .vdValid_o  (vdValid),
    .nCSync_o   (nCSync),
    .nVSync_o   (nVSync),
    .nHSync_o   (nHSync)
  );

  // 8 ns video clock
  always #4 vclk = ~vclk;

  initial begin
    #watchdogNs;
    $display("Watchdog expired after %0d ns before the tests completed", watchdogNs);
    $display("Simulation finished: FAIL");
    $finish;
  end

  ////////////////////////////////////////
  // Reference model

  // Top bit appended below the sample
  function automatic logic [colorWidthO-1:0] widenSample(input logic [colorWidthI-1:0] s);
    logic [colorWidthO-1:0] w;
    w    = {s, 1'b0};
    w[0] = s[colorWidthI-1];
    return w;
  endfunction

  function automatic logic [colorWidthO-1:0] clip(input int v);
    logic [colorWidthO-1:0] res;
    if (v < 0) begin
      res = 8'h00;
    end else if (v > 255) begin
      res = 8'hff;
    end else begin
      res = v[7:0];
    end
    return res;
  endfunction

  function automatic logic [3*colorWidthO-1:0] refPixel(
    input logic [1:0]             m,
    input logic [3:0]             nib,
    input logic [colorWidthI-1:0] r7,
    input logic [colorWidthI-1:0] g7,
    input logic [colorWidthI-1:0] b7
  );
    int r;
    int g;
    int b;
    logic [colorWidthO-1:0] c0;
    logic [colorWidthO-1:0] c1;
    logic [colorWidthO-1:0] c2;
    r = int'(widenSample(r7));
    g = int'(widenSample(g7));
    b = int'(widenSample(b7));
    if (m == modeYpbpr) begin
      // Y, then Pb and Pr around mid-scale
      c0 = clip((77 * r + 150 * g + 29 * b) >>> 8);
      c1 = clip(((-43 * r - 85 * g + 128 * b) >>> 8) + 128);
      c2 = clip(((128 * r - 107 * g - 21 * b) >>> 8) + 128);
    end else begin
      c0 = widenSample(r7);
      c1 = widenSample(g7);
      c2 = widenSample(b7);
    end
    // Sync on channel 1 outside plain RGB
    if ((m != modeRgb) && !nib[csIdx]) begin
      c1 = '0;
    end
    return {c0, c1, c2};
  endfunction

  // YPbPr jumper overrides RGsB
  function automatic logic [1:0] decodeJumpers();
    logic [1:0] m;
    if (!nEnYpbpr) begin
      m = modeYpbpr;
    end else if (!nEnRgsb) begin
      m = modeRgsb;
    end else begin
      m = modeRgb;
    end
    return m;
  endfunction

  function automatic logic [colorWidthI-1:0] randColor();
    logic [31:0] w;
    w = $random(seed);
    return w[colorWidthI-1:0];
  endfunction

  ////////////////////////////////////////
  // Compare tasks

  task automatic checkVd(input logic [3*colorWidthO-1:0] got,
                         input logic [3*colorWidthO-1:0] exp);
    if (got !== exp) begin
      $display("** Error: vd_o got 0x%06h, expected 0x%06h at %0t ns", got, exp, $time);
      errorCount++;
    end
  endtask

  // Order is {nCSync_o, nVSync_o, nHSync_o}
  task automatic checkSync(input logic [2:0] got, input logic [2:0] exp);
    if (got !== exp) begin
      $display("** Error: {nCSync_o,nVSync_o,nHSync_o} got 0x%h, expected 0x%h at %0t ns",
               got, exp, $time);
      errorCount++;
    end
  endtask

  ////////////////////////////////////////
  // Bus drivers

  task automatic driveBus(input logic sync, input logic [colorWidthI-1:0] value);
    @(posedge vclk);
    #1;
    nVDSync = sync;
    vd      = value;
  endtask

  task automatic sendPixel(input logic [3:0] nib, input logic [colorWidthI-1:0] r7,
                           input logic [colorWidthI-1:0] g7, input logic [colorWidthI-1:0] b7);
    logic [1:0] newMode;
    newMode = curMode;
    // Falling vsync between valid pixels latches the jumpers
    if (prevVs && !nib[vsIdx]) begin
      newMode = decodeJumpers();
    end
    expVd.push_back(refPixel(curMode, nib, r7, g7, b7));
    expSync.push_back({nib[csIdx], nib[vsIdx], nib[hsIdx]});
    expCheck.push_back(!skipNext);
    // Pixel right after a mode change may use either mode
    skipNext = (newMode != curMode);
    curMode  = newMode;
    prevVs   = nib[vsIdx];
    driveBus(1'b0, {3'b000, nib});
    driveBus(1'b1, r7);
    driveBus(1'b1, g7);
    driveBus(1'b1, b7);
  endtask

  // Sync, red and green only
  task automatic sendPartial(input logic [3:0] nib, input logic [colorWidthI-1:0] r7,
                             input logic [colorWidthI-1:0] g7);
    driveBus(1'b0, {3'b000, nib});
    driveBus(1'b1, r7);
    driveBus(1'b1, g7);
  endtask

  task automatic sendRandom(input int count, input logic [3:0] nib, input bit randSync);
    logic [31:0] w;
    logic [3:0]  n;
    for (int i = 0; i < count; i++) begin
      n = nib;
      if (randSync) begin
        w = $random(seed);
        n = w[3:0];
      end
      sendPixel(n, randColor(), randColor(), randColor());
    end
  endtask

  task automatic waitDrain();
    int n;
    n = 0;
    while ((expVd.size() != 0) && (n < 64)) begin
      @(negedge vclk);
      n++;
    end
    if (expVd.size() != 0) begin
      $display("Missing output: %0d expected pixels never appeared", expVd.size());
      errorCount++;
      expVd.delete();
      expSync.delete();
      expCheck.delete();
    end
    // Room for stray pixels
    repeat (8) @(negedge vclk);
    // Next jumper change lands just after a rising edge
    @(posedge vclk);
    #1;
  endtask

  ////////////////////////////////////////
  // Output monitor

  // Outputs settle after the rising edge
  always @(negedge vclk) begin
    if (!reset && vdValid) begin
      if (expVd.size() == 0) begin
        $display("Unexpected output pixel at %0t ns with nothing pending", $time);
        errorCount++;
      end else begin
        monVd    = expVd.pop_front();
        monSync  = expSync.pop_front();
        monCheck = expCheck.pop_front();
        if (monCheck) begin
          checkVd(vdOut, monVd);
        end
        checkSync({nCSync, nVSync, nHSync}, monSync);
        pixelsChecked++;
      end
    end
  end

  `include "n64advTbTests.svh"

  initial begin
    vclk     = 1'b0;
    reset    = 1'b1;
    nVDSync  = 1'b1;
    vd       = '0;
    nEnRgsb  = 1'b1;
    nEnYpbpr = 1'b1;
    curMode  = modeRgb;
    prevVs   = 1'b1;
    skipNext = 1'b0;
    repeat (3) @(posedge vclk);
    #1;
    reset = 1'b0;
    testReset();
    testRgbStream();
    testYpbpr();
    testSyncOnGreen();
    testModeAtVsync();
    testTruncated();
    $display("Errors: %0d, pixels checked: %0d", errorCount, pixelsChecked);
    if (errorCount == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+tb
verilog/n64advPkg.sv
verilog/pixelIf.sv
verilog/n64VideoDemux.sv
verilog/colorSpaceConv.sv
verilog/outputFormatter.sv
verilog/n64advCore.sv
tb/n64advTb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/100ps
LINTFLAGS = --lint-only --timing --timescale 1ns/100ps
TOP       = n64advTb
FILELIST  = vlog.f
OBJDIR    = obj_dir
PASS_MSG  = Simulation finished: PASS

.PHONY: run build lint clean

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
